/* Bender.yml */
package:
  name: cache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/cache_pkg.sv
      - logic/cache_array_if.sv
      - logic/cache_ctrl.sv
      - logic/refill_counter.sv
      - logic/cache_tag_array.sv
      - logic/cache_data_array.sv
      - logic/cache_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/cache_checker.sv
      - sim/cache_tb.sv

/* include/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// address split: tag | index | offset
`define CACHE_INDEX_W   8
`define CACHE_TAG_W     20
`define CACHE_OFFSET_W  4

// two ways, one lru bit per set
`define CACHE_WAYS      2
`define CACHE_WAY_W     1

// four 32-bit banks per line
`define CACHE_BANKS     4
`define CACHE_BANK_W    2
`define CACHE_WORD_W    32

`endif

/* logic/cache_array_if.sv */
`include "cache_config.svh"

interface cache_array_if;
    import cache_pkg::*;

    // read side, both arrays
    logic [`CACHE_INDEX_W-1:0]  rd_index;
    logic [`CACHE_TAG_W-1:0]    lookup_tag;     // also the tag written on refill
    logic [`CACHE_WAY_W-1:0]    line_way;

    // write side
    logic [`CACHE_INDEX_W-1:0]  wr_index;
    logic                       tag_we;
    logic [`CACHE_WAY_W-1:0]    tag_way;        // data writes follow this way too
    logic                       dirty_set;
    logic [`CACHE_WAY_W-1:0]    dirty_way;
    logic                       lru_touch;
    logic [`CACHE_WAY_W-1:0]    lru_way;
    logic [`CACHE_BANKS-1:0][3:0] bank_we;      // byte strobes per bank
    word_t                      bank_wdata [`CACHE_BANKS];

    // tag array results
    logic                       hit;
    logic [`CACHE_WAY_W-1:0]    hit_way;
    logic [`CACHE_WAY_W-1:0]    victim_way;
    logic                       victim_dirty;
    logic [`CACHE_TAG_W-1:0]    victim_tag;

    // data array result
    line_t                      line_rdata;

    modport ctrl (
        output rd_index, lookup_tag, line_way, wr_index, tag_we, tag_way,
               dirty_set, dirty_way, lru_touch, lru_way, bank_we, bank_wdata,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag, line_rdata
    );

    modport tags (
        input  rd_index, lookup_tag, wr_index, tag_we, tag_way,
               dirty_set, dirty_way, lru_touch, lru_way,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport data (
        input  rd_index, line_way, wr_index, tag_way, bank_we, bank_wdata,
        output line_rdata
    );

endinterface

/* logic/cache_ctrl.sv */
`include "cache_config.svh"

module cache_ctrl (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid,
    input  cache_pkg::cache_op_e        op,
    input  logic [`CACHE_INDEX_W-1:0]   index,
    input  logic [`CACHE_TAG_W-1:0]     tag,
    input  logic [`CACHE_OFFSET_W-1:0]  offset,
    input  logic [3:0]                  wstrb,
    input  cache_pkg::word_t            wdata,
    output logic                        addr_ok,
    output logic                        data_ok,
    output cache_pkg::word_t            rdata,
    output logic                        rd_req,
    output logic [31:0]                 rd_addr,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  logic                        ret_last,
    input  cache_pkg::word_t            ret_data,
    output logic                        wr_req,
    output logic [31:0]                 wr_addr,
    output cache_pkg::line_t            wr_data,
    input  logic                        wr_rdy,
    cache_array_if.ctrl                 arr,
    output logic                        count_en,
    input  cache_pkg::beat_t            beat,
    input  logic                        last_beat
);
    import cache_pkg::*;

    cache_state_e               state;
    cache_state_e               state_nxt;

    // request buffer
    cache_op_e                  op_q;
    logic [`CACHE_INDEX_W-1:0]  index_q;
    logic [`CACHE_TAG_W-1:0]    tag_q;
    logic [`CACHE_OFFSET_W-1:0] offset_q;
    logic [3:0]                 wstrb_q;
    word_t                      wdata_q;

    logic                       hit_now;
    logic                       fill_done;
    logic [`CACHE_WAY_W-1:0]    way_sel;
    beat_t                      word_idx;
    word_t                      merged;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            op_q     <= op;
            index_q  <= index;
            tag_q    <= tag;
            offset_q <= offset;
            wstrb_q  <= wstrb;
            wdata_q  <= wdata;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (valid) state_nxt = LOOKUP;
            LOOKUP: begin
                if (arr.hit)               state_nxt = IDLE;
                else if (arr.victim_dirty) state_nxt = MISS;
                else                       state_nxt = REPLACE;
            end
            MISS:    if (wr_rdy) state_nxt = REPLACE;
            REPLACE: if (rd_rdy) state_nxt = REFILL;
            REFILL:  if (last_beat) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign word_idx  = offset_q[`CACHE_OFFSET_W-1:2];
    assign hit_now   = (state == LOOKUP) && arr.hit;
    assign fill_done = (state == REFILL) && last_beat;
    assign way_sel   = hit_now ? arr.hit_way : arr.victim_way;  // victim outside a hit
    assign count_en  = (state == REFILL) && ret_valid;

    // buffered write bytes over the returned word
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            merged[8*k +: 8] = wstrb_q[k] ? wdata_q[8*k +: 8] : ret_data[8*k +: 8];
        end
    end

    // hit writes use the cpu strobes, refill writes a whole bank per beat
    always_comb begin
        for (int b = 0; b < `CACHE_BANKS; b++) begin
            arr.bank_wdata[b] = (op_q == OP_WRITE && b == word_idx) ? merged : ret_data;
            if (hit_now && op_q == OP_WRITE && b == word_idx) begin
                arr.bank_we[b] = wstrb_q;
            end else if (count_en && b == beat) begin
                arr.bank_we[b] = 4'hf;
            end else begin
                arr.bank_we[b] = 4'h0;
            end
        end
    end

    assign arr.rd_index   = (state == IDLE) ? index : index_q;
    assign arr.lookup_tag = tag_q;
    assign arr.line_way   = way_sel;
    assign arr.wr_index   = index_q;
    assign arr.tag_we     = fill_done;
    assign arr.tag_way    = way_sel;
    assign arr.dirty_set  = (op_q == OP_WRITE) && (hit_now || fill_done);
    assign arr.dirty_way  = way_sel;
    assign arr.lru_touch  = hit_now || fill_done;
    assign arr.lru_way    = way_sel;

    assign addr_ok = (state == IDLE);
    assign data_ok = hit_now ||
                     (count_en && ((op_q == OP_READ) ? (beat == word_idx) : last_beat));
    assign rdata   = (state == REFILL) ? ret_data : arr.line_rdata[word_idx*32 +: 32];

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {tag_q, index_q, {`CACHE_OFFSET_W{1'b0}}};
    assign wr_req  = (state == MISS);
    assign wr_addr = {arr.victim_tag, index_q, {`CACHE_OFFSET_W{1'b0}}};
    assign wr_data = arr.line_rdata;    // victim line, set held steady in MISS

    // write-back must not drop or change before the bridge takes it
    wr_hold: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
        else $error("wr_req dropped or changed before wr_rdy");

    req_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
        else $error("rd_req and wr_req high together");

endmodule

/* logic/cache_data_array.sv */
`include "cache_config.svh"

module cache_data_array (
    input  logic        clk,
    cache_array_if.data arr
);
    import cache_pkg::*;

    localparam int SETS = 1 << `CACHE_INDEX_W;

    line_t way_line [`CACHE_WAYS];  // registered line of each way

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        word_t mem [`CACHE_BANKS][SETS];
        line_t line_q;
        logic  way_hit;

        assign way_hit = (arr.tag_way == w);

        always_ff @(posedge clk) begin
            for (int b = 0; b < `CACHE_BANKS; b++) begin
                for (int k = 0; k < 4; k++) begin
                    if (way_hit && arr.bank_we[b][k]) begin
                        mem[b][arr.wr_index][8*k +: 8] <= arr.bank_wdata[b][8*k +: 8];
                    end
                end
                // old data on a same-cycle write, no bypass
                line_q[32*b +: 32] <= mem[b][arr.rd_index];
            end
        end

        assign way_line[w] = line_q;
    end

    // way picked late, after the tag compare
    assign arr.line_rdata = way_line[arr.line_way];

endmodule

/* logic/cache_pkg.sv */
`include "cache_config.svh"

package cache_pkg;

    // controller states
    typedef enum logic [2:0] {
        IDLE,       // waiting for a cpu request
        LOOKUP,     // tag compare, hit response
        MISS,       // dirty victim write-back
        REPLACE,    // line read request
        REFILL      // collecting returned beats
    } cache_state_e;

    // cpu request opcode
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    typedef logic [`CACHE_WORD_W-1:0] word_t;

    // bank 0 sits in the low word
    typedef logic [`CACHE_BANKS*`CACHE_WORD_W-1:0] line_t;

    // bank number, also the refill beat number
    typedef logic [`CACHE_BANK_W-1:0] beat_t;

endpackage

/* logic/cache_tag_array.sv */
`include "cache_config.svh"

module cache_tag_array (
    input  logic        clk,
    input  logic        resetn,
    cache_array_if.tags arr
);
    localparam int SETS  = 1 << `CACHE_INDEX_W;
    localparam int WAY_W = `CACHE_WAY_W;

    logic [`CACHE_TAG_W-1:0] tag_mem    [`CACHE_WAYS][SETS];
    logic [SETS-1:0]         valid_bits [`CACHE_WAYS];
    logic [SETS-1:0]         dirty_bits [`CACHE_WAYS];
    logic [WAY_W-1:0]        mru_bits   [SETS];     // last used way per set

    // registered read of the set at rd_index
    logic [`CACHE_TAG_W-1:0] tag_r [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]  valid_r;
    logic [`CACHE_WAYS-1:0]  dirty_r;
    logic [WAY_W-1:0]        mru_r;

    logic [`CACHE_WAYS-1:0]  hit_vec;
    logic                    inv_found;
    logic [WAY_W-1:0]        inv_way;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '{default: '0};
            dirty_bits <= '{default: '0};
            mru_bits   <= '{default: '0};
        end else begin
            if (arr.tag_we) begin
                valid_bits[arr.tag_way][arr.wr_index] <= 1'b1;
                dirty_bits[arr.tag_way][arr.wr_index] <= 1'b0;     // fresh line starts clean
            end
            if (arr.dirty_set) begin
                dirty_bits[arr.dirty_way][arr.wr_index] <= 1'b1;
            end
            if (arr.lru_touch) begin
                mru_bits[arr.wr_index] <= arr.lru_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr.tag_we) begin
            tag_mem[arr.tag_way][arr.wr_index] <= arr.lookup_tag;
        end
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            tag_r[w]   <= tag_mem[w][arr.rd_index];
            valid_r[w] <= valid_bits[w][arr.rd_index];
            dirty_r[w] <= dirty_bits[w][arr.rd_index];
        end
        mru_r <= mru_bits[arr.rd_index];
    end

    always_comb begin
        arr.hit_way = '0;
        inv_found   = 1'b0;
        inv_way     = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_vec[w] = valid_r[w] && (tag_r[w] == arr.lookup_tag);
            if (hit_vec[w]) arr.hit_way = WAY_W'(w);
        end
        // scan down so the lowest invalid way wins
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_r[w]) begin
                inv_found = 1'b1;
                inv_way   = WAY_W'(w);
            end
        end
    end

    assign arr.hit          = |hit_vec;
    assign arr.victim_way   = inv_found ? inv_way : ~mru_r;
    assign arr.victim_dirty = valid_r[arr.victim_way] && dirty_r[arr.victim_way];
    assign arr.victim_tag   = tag_r[arr.victim_way];

    // refill only allocates on a miss, so a line never lives in both ways
    one_hit: assert property (@(posedge clk) disable iff (!resetn)
        !(hit_vec[0] && hit_vec[1]))
        else $error("tag hit in both ways");

endmodule

/* logic/cache_top.sv */
`include "cache_config.svh"

module cache_top (
    input  logic                        clk,
    input  logic                        resetn,
    // cpu side
    input  logic                        valid,
    input  cache_pkg::cache_op_e        op,
    input  logic [`CACHE_INDEX_W-1:0]   index,
    input  logic [`CACHE_TAG_W-1:0]     tag,
    input  logic [`CACHE_OFFSET_W-1:0]  offset,
    input  logic [3:0]                  wstrb,
    input  cache_pkg::word_t            wdata,
    output logic                        addr_ok,
    output logic                        data_ok,
    output cache_pkg::word_t            rdata,
    // line read
    output logic                        rd_req,
    output logic [31:0]                 rd_addr,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  logic                        ret_last,
    input  cache_pkg::word_t            ret_data,
    // line write-back
    output logic                        wr_req,
    output logic [31:0]                 wr_addr,
    output cache_pkg::line_t            wr_data,
    input  logic                        wr_rdy
);
    import cache_pkg::*;

    logic  count_en;
    beat_t beat;
    logic  last_beat;

    cache_array_if arr_if ();

    cache_ctrl cache_ctrl_inst (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .arr       (arr_if.ctrl),
        .count_en  (count_en),
        .beat      (beat),
        .last_beat (last_beat)
    );

    refill_counter refill_counter_inst (
        .clk       (clk),
        .resetn    (resetn),
        .count_en  (count_en),
        .ret_last  (ret_last),
        .beat      (beat),
        .last_beat (last_beat)
    );

    cache_tag_array cache_tag_array_inst (
        .clk    (clk),
        .resetn (resetn),
        .arr    (arr_if.tags)
    );

    cache_data_array cache_data_array_inst (
        .clk (clk),
        .arr (arr_if.data)
    );

endmodule

/* logic/refill_counter.sv */
`include "cache_config.svh"

module refill_counter (
    input  logic                clk,
    input  logic                resetn,
    input  logic                count_en,
    input  logic                ret_last,
    output cache_pkg::beat_t    beat,
    output logic                last_beat
);
    import cache_pkg::*;

    // beat names the bank of the word now on ret_data
    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat <= '0;
        end else if (count_en) begin
            if (ret_last) begin
                beat <= '0;     // ready for the next line
            end else begin
                beat <= beat + 1'b1;
            end
        end
    end

    assign last_beat = count_en && ret_last;

    // bridge must return exactly one full line per read
    last_on_final: assert property (@(posedge clk) disable iff (!resetn)
        count_en && ret_last |-> beat == beat_t'(`CACHE_BANKS - 1))
        else $error("ret_last seen on beat %0d", beat);

endmodule

/* sim.f */
+incdir+include
logic/cache_pkg.sv
logic/cache_array_if.sv
logic/cache_ctrl.sv
logic/refill_counter.sv
logic/cache_tag_array.sv
logic/cache_data_array.sv
logic/cache_top.sv
sim/cache_checker.sv
sim/cache_tb.sv

/* sim/cache_checker.sv */
`include "cache_config.svh"

module cache_checker (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid,
    input  cache_pkg::cache_op_e        op,
    input  logic [`CACHE_INDEX_W-1:0]   index,
    input  logic [`CACHE_TAG_W-1:0]     tag,
    input  logic [`CACHE_OFFSET_W-1:0]  offset,
    input  logic [3:0]                  wstrb,
    input  cache_pkg::word_t            wdata,
    input  logic                        addr_ok,
    input  logic                        data_ok,
    input  cache_pkg::word_t            rdata,
    input  logic                        rd_req,
    input  logic [31:0]                 rd_addr,
    input  logic                        rd_rdy,
    input  logic                        wr_req,
    input  logic [31:0]                 wr_addr,
    input  cache_pkg::line_t            wr_data,
    input  logic                        wr_rdy,
    output int                          error_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    localparam int SETS = 1 << `CACHE_INDEX_W;

    word_t                      arch [int unsigned];    // cpu view of memory
    logic [`CACHE_TAG_W-1:0]    m_tag   [`CACHE_WAYS][SETS];
    logic [`CACHE_WAYS-1:0]     m_valid [SETS];
    logic [`CACHE_WAYS-1:0]     m_dirty [SETS];
    logic                       m_mru   [SETS];

    // request in flight
    logic                       pending;
    logic                       exp_hit;
    logic                       exp_wb;
    logic                       way_q;
    logic                       idle_due;       // addr_ok owed in the next cycle
    int                         cycles;
    int                         wb_seen;
    int                         rd_seen;
    cache_op_e                  op_q;
    logic [`CACHE_INDEX_W-1:0]  index_q;
    logic [`CACHE_TAG_W-1:0]    tag_q;
    logic [`CACHE_OFFSET_W-1:0] offset_q;
    logic [3:0]                 wstrb_q;
    word_t                      wdata_q;
    logic [31:0]                exp_wr_addr;
    line_t                      exp_wr_data;
    int                         errors = 0;

    assign error_count = errors;

    // power-up memory contents, unique per address
    function automatic word_t init_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'ha5c3_0f96;
    endfunction

    function automatic word_t read_arch(input logic [31:0] a);
        if (arch.exists(a)) return arch[a];
        return init_word(a);
    endfunction

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_fault(input string msg);
        $display("%0t check failed: %s", $time, msg);
        errors++;
    endtask

    task automatic accept_request();
        pending  = 1'b1;
        cycles   = 0;
        wb_seen  = 0;
        rd_seen  = 0;
        op_q     = op;
        index_q  = index;
        tag_q    = tag;
        offset_q = offset;
        wstrb_q  = wstrb;
        wdata_q  = wdata;
        exp_hit  = 1'b0;
        exp_wb   = 1'b0;
        way_q    = 1'b0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[index][w] && m_tag[w][index] == tag) begin
                exp_hit = 1'b1;
                way_q   = w[0];
            end
        end
        if (!exp_hit) begin
            if (!m_valid[index][0]) way_q = 1'b0;
            else if (!m_valid[index][1]) way_q = 1'b1;
            else way_q = ~m_mru[index];     // least recently used
            exp_wb      = m_valid[index][way_q] && m_dirty[index][way_q];
            exp_wr_addr = {m_tag[way_q][index], index, {`CACHE_OFFSET_W{1'b0}}};
            for (int b = 0; b < `CACHE_BANKS; b++) begin
                exp_wr_data[32*b +: 32] = read_arch(exp_wr_addr + 32'(4*b));
            end
        end
    endtask

    task automatic finish_request();
        logic [31:0] a;
        word_t       exp;
        a   = {tag_q, index_q, offset_q[`CACHE_OFFSET_W-1:2], 2'b00};
        exp = read_arch(a);
        if (exp_hit && cycles != 1) report_fault("hit response not one cycle after acceptance");
        if (wb_seen != (exp_wb ? 1 : 0)) report_fault("wrong number of write-backs");
        if (rd_seen != (exp_hit ? 0 : 1)) report_fault("wrong number of line reads");
        if (op_q == OP_READ) begin
            if (rdata !== exp) report_value("rdata", rdata, exp);
        end else begin
            for (int k = 0; k < 4; k++) begin
                if (wstrb_q[k]) exp[8*k +: 8] = wdata_q[8*k +: 8];
            end
            arch[a] = exp;
        end
        if (!exp_hit) begin
            m_tag[way_q][index_q]   = tag_q;
            m_valid[index_q][way_q] = 1'b1;
            m_dirty[index_q][way_q] = 1'b0;
        end
        if (op_q == OP_WRITE) m_dirty[index_q][way_q] = 1'b1;
        m_mru[index_q] = way_q;
        // hits, write misses and reads of word 3 end on the controller's last busy cycle
        idle_due = exp_hit || (op_q == OP_WRITE) || (offset_q[`CACHE_OFFSET_W-1:2] == 2'd3);
        pending  = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < SETS; s++) begin
                m_valid[s] = '0;
                m_dirty[s] = '0;
                m_mru[s]   = 1'b0;
            end
            pending  = 1'b0;
            idle_due = 1'b0;
        end else begin
            if (pending) cycles++;
            if (idle_due && !addr_ok) report_fault("addr_ok not back the cycle after the response");
            idle_due = 1'b0;
            if (pending && addr_ok) report_fault("addr_ok high while a request is in flight");
            if (wr_req) begin
                if (!pending || !exp_wb || wb_seen != 0) begin
                    report_fault("unexpected write-back request");
                end else begin
                    if (wr_addr !== exp_wr_addr) report_value("wr_addr", wr_addr, exp_wr_addr);
                    if (wr_data !== exp_wr_data) report_value("wr_data", wr_data, exp_wr_data);
                    if (wr_rdy) wb_seen++;
                end
            end
            if (rd_req) begin
                if (!pending || exp_hit || rd_seen != 0) begin
                    report_fault("unexpected line read request");
                end else begin
                    if (exp_wb && wb_seen == 0) report_fault("line read before the write-back");
                    if (rd_addr !== {tag_q, index_q, {`CACHE_OFFSET_W{1'b0}}}) begin
                        report_value("rd_addr", rd_addr, {tag_q, index_q, 4'h0});
                    end
                    if (rd_rdy) rd_seen++;
                end
            end
            if (data_ok) begin
                if (!pending) report_fault("data_ok with no request in flight");
                else finish_request();
            end
            if (valid && addr_ok) begin
                if (pending) report_fault("request accepted while another was in flight");
                accept_request();
            end
        end
    end

endmodule

/* sim/cache_tb.sv */
`include "cache_config.svh"

module cache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    localparam int CYCLES_PER_TEST = 60;

    typedef struct packed {
        cache_op_e                  op;
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
        logic [3:0]                 wstrb;
        word_t                      wdata;
    } stim_t;

    logic                       clk;
    logic                       resetn;
    logic                       valid;
    cache_op_e                  op;
    logic [`CACHE_INDEX_W-1:0]  index;
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_OFFSET_W-1:0] offset;
    logic [3:0]                 wstrb;
    word_t                      wdata;
    logic                       addr_ok;
    logic                       data_ok;
    word_t                      rdata;
    logic                       rd_req;
    logic [31:0]                rd_addr;
    logic                       rd_rdy;
    logic                       ret_valid;
    logic                       ret_last;
    word_t                      ret_data;
    logic                       wr_req;
    logic [31:0]                wr_addr;
    line_t                      wr_data;
    logic                       wr_rdy;
    int                         error_count;

    stim_t      stim_q [$];
    string      note_q [$];
    word_t      backing [int unsigned];     // written-back words, by byte address

    always #5 clk = ~clk;

    cache_top cache_top_inst (.*);

    cache_checker cache_checker_inst (.*);

    // power-up memory contents, unique per address
    function automatic word_t init_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'ha5c3_0f96;
    endfunction

    function automatic word_t mem_word(input logic [31:0] a);
        if (backing.exists(a)) return backing[a];
        return init_word(a);
    endfunction

    task automatic add_entry(input cache_op_e o, input logic [19:0] t, input logic [7:0] i,
                             input logic [3:0] off, input logic [3:0] s, input word_t d,
                             input string note);
        stim_q.push_back('{op: o, tag: t, index: i, offset: off, wstrb: s, wdata: d});
        note_q.push_back(note);
    endtask

    task automatic build_table();
        add_entry(OP_READ,  20'h00001, 8'h10, 4'h4, 4'h0, 32'h0, "read miss, way 0 fill");
        add_entry(OP_READ,  20'h00001, 8'h10, 4'h8, 4'h0, 32'h0, "read hit same line");
        add_entry(OP_WRITE, 20'h00001, 8'h10, 4'h4, 4'b0101, 32'h1122_3344, "write hit, bytes 0 2");
        add_entry(OP_READ,  20'h00001, 8'h10, 4'h4, 4'h0, 32'h0, "read back partial write");
        add_entry(OP_WRITE, 20'h00002, 8'h20, 4'hc, 4'b1100, 32'hdead_beef, "write miss allocate");
        add_entry(OP_READ,  20'h00002, 8'h20, 4'hc, 4'h0, 32'h0, "read merged word");
        add_entry(OP_READ,  20'h00002, 8'h20, 4'h0, 4'h0, 32'h0, "read fetched word");
        add_entry(OP_READ,  20'h00003, 8'h10, 4'h0, 4'h0, 32'h0, "fill way 1, dirty way 0 lru");
        add_entry(OP_READ,  20'h00004, 8'h10, 4'h0, 4'h0, 32'h0, "dirty eviction");
        add_entry(OP_READ,  20'h00001, 8'h10, 4'h4, 4'h0, 32'h0, "evicted line from memory");
        add_entry(OP_READ,  20'h00005, 8'h30, 4'h0, 4'h0, 32'h0, "lru set, way a");
        add_entry(OP_READ,  20'h00006, 8'h30, 4'h4, 4'h0, 32'h0, "lru set, way b");
        add_entry(OP_READ,  20'h00005, 8'h30, 4'h8, 4'h0, 32'h0, "touch way a");
        add_entry(OP_READ,  20'h00007, 8'h30, 4'hc, 4'h0, 32'h0, "miss evicts way b");
        add_entry(OP_READ,  20'h00005, 8'h30, 4'h0, 4'h0, 32'h0, "way a still hits");
        add_entry(OP_READ,  20'h00006, 8'h30, 4'h4, 4'h0, 32'h0, "way b misses");
        add_entry(OP_WRITE, 20'h00008, 8'h40, 4'h0, 4'b1111, 32'h0bad_cafe, "write miss way 0");
        add_entry(OP_WRITE, 20'h00009, 8'h40, 4'h4, 4'b0011, 32'h5555_aaaa, "write miss way 1");
        add_entry(OP_READ,  20'h0000a, 8'h40, 4'h8, 4'h0, 32'h0, "evict dirty way 0");
        add_entry(OP_READ,  20'h00008, 8'h40, 4'h0, 4'h0, 32'h0, "evict dirty way 1");
        add_entry(OP_READ,  20'h00009, 8'h40, 4'h4, 4'h0, 32'h0, "clean eviction, merged data");
        add_entry(OP_WRITE, 20'h00008, 8'h40, 4'hc, 4'b1000, 32'h7700_0000, "write hit top byte");
        add_entry(OP_READ,  20'h00008, 8'h40, 4'hc, 4'h0, 32'h0, "read top byte back");
        add_entry(OP_READ,  20'hfffff, 8'hff, 4'hc, 4'h0, 32'h0, "last set, all-ones tag");
    endtask

    // one request, returns on the data_ok cycle
    task automatic apply_request(input stim_t s);
        while (!addr_ok) @(negedge clk);
        valid  = 1'b1;
        op     = s.op;
        tag    = s.tag;
        index  = s.index;
        offset = s.offset;
        wstrb  = s.wstrb;
        wdata  = s.wdata;
        @(negedge clk);
        valid = 1'b0;
        do @(posedge clk); while (!data_ok);
    endtask

    // bridge model, one line transfer at a time
    always begin : bridge
        logic [31:0] line_addr;
        @(negedge clk);
        if (resetn && wr_req) begin
            repeat ($urandom_range(3)) @(negedge clk);
            for (int b = 0; b < `CACHE_BANKS; b++) begin
                backing[wr_addr + 32'(4*b)] = wr_data[32*b +: 32];
            end
            wr_rdy = 1'b1;
            @(negedge clk);
            wr_rdy = 1'b0;
        end else if (resetn && rd_req) begin
            line_addr = rd_addr;
            repeat ($urandom_range(3)) @(negedge clk);
            rd_rdy = 1'b1;
            @(negedge clk);
            rd_rdy = 1'b0;
            for (int b = 0; b < `CACHE_BANKS; b++) begin
                repeat ($urandom_range(2)) @(negedge clk);     // gap before the beat
                ret_valid = 1'b1;
                ret_last  = (b == `CACHE_BANKS - 1);
                ret_data  = mem_word(line_addr + 32'(4*b));
                @(negedge clk);
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

    initial begin
        #1;
        #(stim_q.size() * CYCLES_PER_TEST * 10);
        $display("watchdog expired before all requests completed");
        $display("Test failures found");
        $finish;
    end

    initial begin
        int errs_before;
        int failed_tests;
        void'($urandom(32'h108f));
        clk       = 1'b0;
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = OP_READ;
        tag       = '0;
        index     = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        failed_tests = 0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        foreach (stim_q[i]) begin
            errs_before = error_count;
            apply_request(stim_q[i]);
            @(negedge clk);     // checker has settled by now
            if (error_count == errs_before) begin
                $display("test %0d ok: %s", i, note_q[i]);
            end else begin
                failed_tests++;
                $display("test %0d FAILED: %s", i, note_q[i]);
            end
        end
        while (!addr_ok) @(negedge clk);    // trailing refill beats

        $display("%0d tests, %0d failed, %0d errors", stim_q.size(), failed_tests, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
